//--- all.f
+incdir+bench
logic/isaPkg.sv
logic/pipePkg.sv
logic/regFile.sv
logic/instrDecoder.sv
logic/alu.sv
logic/hazardUnit.sv
logic/cpuCore.sv
bench/cpuCoreTb.sv

//--- Bender.yml
package:
  name: cpuCore

sources:
  - logic/isaPkg.sv
  - logic/pipePkg.sv
  - logic/regFile.sv
  - logic/instrDecoder.sv
  - logic/alu.sv
  - logic/hazardUnit.sv
  - logic/cpuCore.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/cpuCoreTb.sv

//--- bench/isaModel.svh
// Instruction-level reference model for the pipelined core
// builds a random forward-branching program with a register dump at its end,
// a random data memory image, and the ordered list of stores the program makes
`ifndef isaModelSvh
`define isaModelSvh

localparam int bodyLen = 200;
localparam int initLen = 31;
localparam int dumpBase = 224;
localparam int programLen = bodyLen + 31 + 1;
localparam int loopPc = programLen - 1;

wordT progMem [0:programLen-1];
wordT memImage [0:255];
wordT modelRegs [0:31];
wordT modelMem [0:255];

// expected stores, in program order
wordT expAddrQ [$];
wordT expDataQ [$];
regAddrT expSrcQ [$];

function automatic wordT encodeR(aluOpT op, regAddrT rd, regAddrT rs, regAddrT rt,
                                 logic [4:0] shamt);
    return {opR, rd, rs, rt, shamt, op, 2'b00};
endfunction

function automatic wordT encodeI(opcodeT op, regAddrT rd, regAddrT rs, logic [16:0] imm);
    return {op, rd, rs, imm};
endfunction

function automatic wordT encodeJ(logic [26:0] target);
    return {opJ, target};
endfunction

function automatic regAddrT randReg();
    return regAddrT'($urandom_range(0, 31));
endfunction

function automatic logic [16:0] randImm();
    return 17'($urandom());
endfunction

// one instruction of the random body at address pc
function automatic wordT randomInstr(int pc);
    int kind;
    int maxSkip;
    int skip;
    kind = $urandom_range(0, 10);
    maxSkip = bodyLen - pc - 1;
    if (maxSkip > 6) begin
        maxSkip = 6;
    end
    skip = $urandom_range(0, maxSkip);
    if (kind <= 3) begin
        return encodeR(aluOpT'($urandom_range(0, 5)), randReg(), randReg(), randReg(),
                       5'($urandom()));
    end else if (kind <= 5) begin
        return encodeI(opAddi, randReg(), randReg(), randImm());
    end else if (kind == 6) begin
        return encodeI(opLw, randReg(), randReg(), randImm());
    end else if (kind <= 8) begin
        return encodeI(opSw, randReg(), randReg(), randImm());
    end
    // branches and jumps only go forward, never past the dump
    case ($urandom_range(0, 3))
        0: return encodeI(opBne, randReg(), randReg(), 17'(skip));
        1: return encodeI(opBlt, randReg(), randReg(), 17'(skip));
        2: return encodeI(opBeq, randReg(), randReg(), 17'(skip));
        default: return encodeJ(27'(pc + 1 + skip));
    endcase
endfunction

task automatic buildProgram();
    int pc;
    regAddrT loadDest;
    // every register gets a known value first
    for (pc = 0; pc < initLen; pc++) begin
        progMem[pc] = encodeI(opAddi, regAddrT'(pc + 1), '0, randImm());
    end
    // a write to r0 right before a store that reads r0
    progMem[initLen] = encodeI(opAddi, '0, randReg(), randImm());
    progMem[initLen + 1] = encodeI(opSw, '0, randReg(), randImm());
    pc = initLen + 2;
    while (pc < bodyLen) begin
        if (($urandom_range(0, 7) == 0) && (pc < bodyLen - 1)) begin
            // load followed at once by a store that uses the loaded word twice
            loadDest = regAddrT'($urandom_range(1, 31));
            progMem[pc] = encodeI(opLw, loadDest, randReg(), randImm());
            progMem[pc + 1] = encodeI(opSw, loadDest, loadDest, randImm());
            pc += 2;
        end else begin
            progMem[pc] = randomInstr(pc);
            pc++;
        end
    end
    for (int i = 1; i <= 31; i++) begin
        progMem[bodyLen + i - 1] = encodeI(opSw, regAddrT'(i), '0, 17'(dumpBase + i - 1));
    end
    progMem[loopPc] = encodeJ(27'(loopPc));
endtask

task automatic buildMemImage();
    for (int i = 0; i < 256; i++) begin
        memImage[i] = $urandom();
    end
endtask

function automatic wordT computeAlu(aluOpT op, wordT a, wordT b, logic [4:0] shamt);
    case (op)
        aluAdd:  return a + b;
        aluSub:  return a - b;
        aluAnd:  return a & b;
        aluOr:   return a | b;
        aluSll:  return a << shamt;
        aluSra:  return wordT'($signed(a) >>> shamt);
        default: return '0;
    endcase
endfunction

// r0 stays zero
task automatic writeModelReg(regAddrT index, wordT value);
    if (index != '0) begin
        modelRegs[index] = value;
    end
endtask

task automatic runModel();
    wordT pc;
    wordT nextPc;
    wordT word;
    wordT a;
    wordT b;
    wordT imm;
    wordT addr;
    opcodeT op;
    regAddrT rd;
    regAddrT rs;
    for (int i = 0; i < 32; i++) begin
        modelRegs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
        modelMem[i] = memImage[i];
    end
    pc = '0;
    while (pc != wordT'(loopPc)) begin
        word = progMem[pc];
        op = opcodeT'(word[31:27]);
        rd = word[26:22];
        rs = word[21:17];
        imm = {{15{word[16]}}, word[16:0]};
        a = modelRegs[rs];
        b = modelRegs[rd];
        addr = a + imm;
        nextPc = pc + 1;
        case (op)
            opR:    writeModelReg(rd, computeAlu(aluOpT'(word[6:2]), a, modelRegs[word[16:12]],
                                                 word[11:7]));
            opAddi: writeModelReg(rd, addr);
            opLw:   writeModelReg(rd, modelMem[addr[7:0]]);
            opSw: begin
                modelMem[addr[7:0]] = b;
                expAddrQ.push_back(addr);
                expDataQ.push_back(b);
                expSrcQ.push_back(rd);
            end
            opBne:  if (b != a) nextPc = pc + 1 + imm;
            opBlt:  if ($signed(b) < $signed(a)) nextPc = pc + 1 + imm;
            opBeq:  if (b == a) nextPc = pc + 1 + imm;
            opJ:    nextPc = {nextPc[31:27], word[26:0]};
            default: ;
        endcase
        pc = nextPc;
    end
endtask

`endif

//--- bench/cpuCoreTb.sv
// Testbench for the five-stage core
// runs a random program with instruction and data memories around the DUT
// and compares every store and the final register dump with the model
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb;
    import isaPkg::*;

    localparam wordT resetPcValue = '0;
    localparam int clockPeriod = 40;
    localparam int resetCycles = 16;

    logic clock;
    logic reset;
    wordT imemAddress;
    wordT fetchWord;
    instrT instr;
    wordT dmemAddress;
    wordT dmemWriteData;
    logic wren;
    wordT dmemReadData;
    wordT dataMem [0:255];

    int storeCount;
    int unsigned seed;
    int unsigned seedDummy;
    wordT prevFetch;
    logic done;

    `include "isaModel.svh"

    cpuCore #(.resetPc(resetPcValue)) dut0 (
        .clock(clock),
        .reset(reset),
        .imemAddress(imemAddress),
        .instr(instr),
        .dmemAddress(dmemAddress),
        .dmemWriteData(dmemWriteData),
        .wren(wren),
        .dmemReadData(dmemReadData)
    );

    initial begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    // instruction memory, a bubble beyond the program
    assign fetchWord = (imemAddress < programLen) ? progMem[imemAddress] : '0;
    assign instr = instrT'(fetchWord);

    // data memory uses the low 8 address bits
    assign dmemReadData = dataMem[dmemAddress[7:0]];

    always @(posedge clock) begin
        if (wren) begin
            dataMem[dmemAddress[7:0]] <= dmemWriteData;
        end
    end

    task automatic failRun();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic checkAddress(string testName, wordT expected, wordT actual);
        if (actual !== expected) begin
            $display("error %s: expected %h, actual %h", testName, expected, actual);
            failRun();
        end
    endtask

    task automatic checkData(string testName, wordT expected, wordT actual);
        if (actual !== expected) begin
            $display("error %s: expected %h, actual %h", testName, expected, actual);
            failRun();
        end
    endtask

    task automatic checkCount(string testName, int expected, int actual);
        if (actual != expected) begin
            $display("error %s: expected %0d, actual %0d", testName, expected, actual);
            failRun();
        end
    endtask

    task automatic checkFlag(string testName, logic expected, logic actual);
        if (actual !== expected) begin
            $display("error %s: expected %b, actual %b", testName, expected, actual);
            failRun();
        end
    endtask

    task automatic checkStore();
        if (storeCount >= expAddrQ.size()) begin
            $display("the DUT stored to %h after the last expected store", dmemAddress);
            failRun();
        end
        checkAddress($sformatf("store %0d address", storeCount), expAddrQ[storeCount],
                     dmemAddress);
        // stores sourced from r0 must carry zero
        if (expSrcQ[storeCount] == '0) begin
            checkData($sformatf("store %0d from r0", storeCount), '0, dmemWriteData);
        end
        checkData($sformatf("store %0d data", storeCount), expDataQ[storeCount],
                  dmemWriteData);
        storeCount++;
    endtask

    // watchdog
    initial begin
        #((programLen + 100) * 4 * clockPeriod);
        $display("timeout: the DUT did not reach the final self-loop");
        failRun();
    end

    initial begin
        reset = 1'b1;
        storeCount = 0;
        done = 1'b0;
        seed = 32'h537e;
        seedDummy = $urandom(seed);
        buildProgram();
        buildMemImage();
        runModel();
        for (int i = 0; i < 256; i++) begin
            dataMem[i] = memImage[i];
        end

        repeat (resetCycles) begin
            @(negedge clock);
            checkFlag("wren in reset", 1'b0, wren);
            checkAddress("pc in reset", resetPcValue, imemAddress);
        end
        reset = 1'b0;
        prevFetch = imemAddress;

        // the second arrival at the self-loop comes from its own redirect
        while (!done) begin
            @(negedge clock);
            if (wren) begin
                checkStore();
            end
            if ((imemAddress == wordT'(loopPc)) && (prevFetch == wordT'(loopPc + 2))) begin
                done = 1'b1;
            end
            prevFetch = imemAddress;
        end

        checkCount("store count", expAddrQ.size(), storeCount);
        for (int i = 1; i <= 31; i++) begin
            checkData($sformatf("dump of r%0d", i), modelRegs[i], dataMem[dumpBase + i - 1]);
        end
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/cpuCore.sv
// Five-stage pipelined core: fetch, decode, execute, memory, writeback
// bypassing into execute and store data, one-cycle load-use stall,
// branches and jumps resolved in execute with a two-instruction flush
`timescale 1ns/1ps
`default_nettype none

module cpuCore #(
    parameter isaPkg::wordT resetPc = '0
) (
    input  logic          clock,
    input  logic          reset,
    output isaPkg::wordT  imemAddress,
    input  isaPkg::instrT instr,
    output isaPkg::wordT  dmemAddress,
    output isaPkg::wordT  dmemWriteData,
    output logic          wren,
    input  isaPkg::wordT  dmemReadData
);
    import isaPkg::*;
    import pipePkg::*;

    wordT pc;
    wordT pcPlus1;
    idStageT idStage;
    exStageT exStage;
    memStageT memStage;
    wbStageT wbStage;

    ctrlT decodeCtrl;
    wordT decodeImm;
    wordT readDataA;
    wordT readDataB;
    fwdSelT fwdA;
    fwdSelT fwdB;
    logic stall;

    wordT operandA;
    wordT operandB;
    wordT aluOperandB;
    wordT aluResult;
    logic isNotEqual;
    logic isLessThan;
    logic redirect;
    wordT redirectTarget;
    wordT memValue;
    wordT storeData;

    function automatic wordT bypass(fwdSelT sel, wordT regValue, wordT memVal, wordT wbVal);
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regValue;
        endcase
    endfunction

    // fetch
    assign pcPlus1 = pc + wordT'(1);
    assign imemAddress = pc;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= resetPc;
        end else if (redirect) begin
            pc <= redirectTarget;
        end else if (!stall) begin
            pc <= pcPlus1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || redirect) begin
            idStage <= '0;
        end else if (!stall) begin
            idStage.pcPlus1 <= pcPlus1;
            idStage.instr <= instr;
        end
    end

    // decode
    instrDecoder decoder0 (
        .instr(idStage.instr),
        .ctrl(decodeCtrl),
        .immediate(decodeImm)
    );

    regFile regFile0 (
        .clock(clock),
        .reset(reset),
        .readIndexA(decodeCtrl.srcA),
        .readIndexB(decodeCtrl.srcB),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .writeEnable(wbStage.ctrl.regWrite),
        .writeIndex(wbStage.ctrl.dest),
        .writeData(wbStage.writeValue)
    );

    hazardUnit hazard0 (
        .decodeCtrl(decodeCtrl),
        .executeCtrl(exStage.ctrl),
        .memoryCtrl(memStage.ctrl),
        .writebackCtrl(wbStage.ctrl),
        .fwdA(fwdA),
        .fwdB(fwdB),
        .stall(stall)
    );

    // a stalled decode sends a bubble on
    always_ff @(posedge clock) begin
        if (reset || redirect || stall) begin
            exStage <= '0;
        end else begin
            exStage.ctrl <= decodeCtrl;
            exStage.pcPlus1 <= idStage.pcPlus1;
            exStage.operandA <= readDataA;
            exStage.operandB <= readDataB;
            exStage.immediate <= decodeImm;
        end
    end

    // execute
    assign memValue = memStage.ctrl.memRead ? dmemReadData : memStage.aluResult;
    assign operandA = bypass(fwdA, exStage.operandA, memValue, wbStage.writeValue);
    assign operandB = bypass(fwdB, exStage.operandB, memValue, wbStage.writeValue);
    assign aluOperandB = exStage.ctrl.useImm ? exStage.immediate : operandB;

    alu alu0 (
        .operandA(operandA),
        .operandB(aluOperandB),
        .aluOp(exStage.ctrl.aluOp),
        .shamt(exStage.ctrl.shamt),
        .result(aluResult),
        .isNotEqual(isNotEqual),
        .isLessThan(isLessThan)
    );

    // A is rs and B is rd, so rd < rs means B < A
    always_comb begin
        case (exStage.ctrl.branch)
            brBne:   redirect = isNotEqual;
            brBlt:   redirect = isNotEqual && !isLessThan;
            brBeq:   redirect = !isNotEqual;
            brJump:  redirect = 1'b1;
            default: redirect = 1'b0;
        endcase
    end

    assign redirectTarget = (exStage.ctrl.branch == brJump) ?
        {exStage.pcPlus1[xlen-1:targetW], exStage.immediate[targetW-1:0]} :
        exStage.pcPlus1 + exStage.immediate;

    always_ff @(posedge clock) begin
        if (reset) begin
            memStage <= '0;
        end else begin
            memStage.ctrl <= exStage.ctrl;
            memStage.aluResult <= aluResult;
            memStage.storeData <= operandB;
        end
    end

    // memory, with store data refreshed from writeback
    assign storeData = (wbStage.ctrl.regWrite && (wbStage.ctrl.dest == memStage.ctrl.srcB)) ?
                       wbStage.writeValue : memStage.storeData;
    assign dmemAddress = memStage.aluResult;
    assign dmemWriteData = storeData;
    assign wren = memStage.ctrl.memWrite;

    always_ff @(posedge clock) begin
        if (reset) begin
            wbStage <= '0;
        end else begin
            wbStage.ctrl <= memStage.ctrl;
            wbStage.writeValue <= memValue;
        end
    end

endmodule

`default_nettype wire

//--- logic/hazardUnit.sv
// Hazard unit
// bypass selects for both execute operands and the load-use stall of decode
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  pipePkg::ctrlT   decodeCtrl,
    input  pipePkg::ctrlT   executeCtrl,
    input  pipePkg::ctrlT   memoryCtrl,
    input  pipePkg::ctrlT   writebackCtrl,
    output pipePkg::fwdSelT fwdA,
    output pipePkg::fwdSelT fwdB,
    output logic            stall
);
    import isaPkg::*;
    import pipePkg::*;

    // a producer matches only if it writes a nonzero register
    function automatic logic producerMatch(ctrlT producer, regAddrT source);
        return producer.regWrite && (producer.dest != '0) && (producer.dest == source);
    endfunction

    // memory stage is younger, so it wins over writeback
    function automatic fwdSelT selectFor(regAddrT source, ctrlT mem, ctrlT wb);
        if (producerMatch(mem, source)) begin
            return fwdMem;
        end else if (producerMatch(wb, source)) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    assign fwdA = selectFor(executeCtrl.srcA, memoryCtrl, writebackCtrl);
    assign fwdB = selectFor(executeCtrl.srcB, memoryCtrl, writebackCtrl);

    // load in execute feeding the instruction in decode
    assign stall = executeCtrl.memRead &&
                   (producerMatch(executeCtrl, decodeCtrl.srcA) ||
                    producerMatch(executeCtrl, decodeCtrl.srcB));

endmodule

`default_nettype wire

//--- logic/alu.sv
// Execute-stage ALU
// add, sub, and, or, sll, sra with wrapping arithmetic, plus compare flags
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  isaPkg::wordT  operandA,
    input  isaPkg::wordT  operandB,
    input  isaPkg::aluOpT aluOp,
    input  logic [4:0]    shamt,
    output isaPkg::wordT  result,
    output logic          isNotEqual,
    output logic          isLessThan
);
    import isaPkg::*;

    wordT difference;

    assign difference = operandA - operandB;

    always_comb begin
        case (aluOp)
            aluAdd:  result = operandA + operandB;
            aluSub:  result = difference;
            aluAnd:  result = operandA & operandB;
            aluOr:   result = operandA | operandB;
            aluSll:  result = operandA << shamt;
            aluSra:  result = wordT'($signed(operandA) >>> shamt);
            default: result = '0;
        endcase
    end

    // flags compare A against B, signed
    assign isNotEqual = (difference != '0);
    assign isLessThan = ($signed(operandA) < $signed(operandB));

endmodule

`default_nettype wire

//--- logic/instrDecoder.sv
// Instruction decoder
// maps a raw instruction word to the pipeline control word and a 32-bit immediate
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  isaPkg::instrT instr,
    output pipePkg::ctrlT ctrl,
    output isaPkg::wordT  immediate
);
    import isaPkg::*;
    import pipePkg::*;

    wordT signExtImm;
    wordT jumpTarget;

    assign signExtImm = {{(xlen-immW){instr.body.i.imm[immW-1]}}, instr.body.i.imm};
    assign jumpTarget = {{(xlen-targetW){1'b0}}, instr.body.target};

    always_comb begin
        ctrl = '0;
        immediate = signExtImm;
        case (instr.opcode)
            opR: begin
                // unsupported ALU ops stay a bubble
                if (instr.body.r.aluOp inside {aluAdd, aluSub, aluAnd, aluOr, aluSll, aluSra}) begin
                    ctrl.aluOp = instr.body.r.aluOp;
                    ctrl.shamt = instr.body.r.shamt;
                    ctrl.srcA = instr.body.r.rs;
                    ctrl.srcB = instr.body.r.rt;
                    ctrl.dest = instr.body.r.rd;
                end
            end
            opAddi, opLw, opSw: begin
                ctrl.aluOp = aluAdd;
                ctrl.useImm = 1'b1;
                ctrl.srcA = instr.body.i.rs;
                ctrl.memRead = (instr.opcode == opLw);
                ctrl.memWrite = (instr.opcode == opSw);
                // loads and stores name rd as the second source
                ctrl.srcB = (instr.opcode == opAddi) ? '0 : instr.body.i.rd;
                ctrl.dest = (instr.opcode == opSw) ? '0 : instr.body.i.rd;
            end
            opBne, opBlt, opBeq: begin
                ctrl.aluOp = aluSub;
                ctrl.srcA = instr.body.i.rs;
                ctrl.srcB = instr.body.i.rd;
                ctrl.branch = (instr.opcode == opBne) ? brBne :
                              (instr.opcode == opBlt) ? brBlt : brBeq;
            end
            opJ: begin
                ctrl.branch = brJump;
                immediate = jumpTarget;
            end
            default: begin
                ctrl = '0;
            end
        endcase
        // writes to r0 are dropped here so bubbles never match a source
        ctrl.regWrite = (ctrl.dest != '0);
    end

endmodule

`default_nettype wire

//--- logic/regFile.sv
// Register file, 31 storage words plus a hardwired zero register
// two combinational read ports, one write port with write-through
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic            clock,
    input  logic            reset,
    input  isaPkg::regAddrT readIndexA,
    input  isaPkg::regAddrT readIndexB,
    output isaPkg::wordT    readDataA,
    output isaPkg::wordT    readDataB,
    input  logic            writeEnable,
    input  isaPkg::regAddrT writeIndex,
    input  isaPkg::wordT    writeData
);
    import isaPkg::*;

    wordT regs [1:2**regAddrW-1];
    logic doWrite;

    // r0 is never stored
    assign doWrite = writeEnable && (writeIndex != '0);

    function automatic wordT readPort(regAddrT index);
        if (index == '0) begin
            return '0;
        end else if (doWrite && (writeIndex == index)) begin
            return writeData;
        end
        return regs[index];
    endfunction

    always_comb begin
        readDataA = readPort(readIndexA);
        readDataB = readPort(readIndexB);
    end

    always_ff @(posedge clock) begin
        if (!reset && doWrite) begin
            regs[writeIndex] <= writeData;
        end
    end

endmodule

`default_nettype wire

//--- logic/pipePkg.sv
// Pipeline definitions: decoded control word, stage registers, bypass selects
`default_nettype none

package pipePkg;

    typedef enum logic [2:0] {
        brNone,
        brBne,
        brBlt,
        brBeq,
        brJump
    } branchT;

    // an all-zero control word is a bubble
    typedef struct packed {
        isaPkg::aluOpT aluOp;
        logic [4:0] shamt;
        logic useImm;
        logic regWrite;
        logic memRead;
        logic memWrite;
        branchT branch;
        isaPkg::regAddrT srcA;
        isaPkg::regAddrT srcB;
        isaPkg::regAddrT dest;
    } ctrlT;

    typedef struct packed {
        isaPkg::wordT pcPlus1;
        isaPkg::instrT instr;
    } idStageT;

    typedef struct packed {
        ctrlT ctrl;
        isaPkg::wordT pcPlus1;
        isaPkg::wordT operandA;
        isaPkg::wordT operandB;
        isaPkg::wordT immediate;
    } exStageT;

    typedef struct packed {
        ctrlT ctrl;
        isaPkg::wordT aluResult;
        isaPkg::wordT storeData;
    } memStageT;

    typedef struct packed {
        ctrlT ctrl;
        isaPkg::wordT writeValue;
    } wbStageT;

    typedef enum logic [1:0] {
        fwdReg,
        fwdMem,
        fwdWb
    } fwdSelT;

endpackage

`default_nettype wire

//--- logic/isaPkg.sv
// Instruction-set definitions for the 32-bit word-addressed teaching core
// field widths, opcode and ALU-op encodings, and the instruction word layout
`default_nettype none

package isaPkg;

    localparam int xlen = 32;
    localparam int regAddrW = 5;
    localparam int immW = 17;
    localparam int targetW = 27;

    typedef logic [xlen-1:0] wordT;
    typedef logic [regAddrW-1:0] regAddrT;

    typedef enum logic [4:0] {
        opR    = 5'd0,
        opJ    = 5'd1,
        opBne  = 5'd2,
        opAddi = 5'd5,
        opBlt  = 5'd6,
        opSw   = 5'd7,
        opLw   = 5'd8,
        opBeq  = 5'd10
    } opcodeT;

    typedef enum logic [4:0] {
        aluAdd = 5'd0,
        aluSub = 5'd1,
        aluAnd = 5'd2,
        aluOr  = 5'd3,
        aluSll = 5'd4,
        aluSra = 5'd5
    } aluOpT;

    // register form, bits 26..0
    typedef struct packed {
        regAddrT rd;
        regAddrT rs;
        regAddrT rt;
        logic [4:0] shamt;
        aluOpT aluOp;
        logic [1:0] unused;
    } rFieldsT;

    // immediate form shares rd and rs with the register form
    typedef struct packed {
        regAddrT rd;
        regAddrT rs;
        logic [immW-1:0] imm;
    } iFieldsT;

    typedef union packed {
        rFieldsT r;
        iFieldsT i;
        logic [targetW-1:0] target;
    } instrBodyT;

    typedef struct packed {
        opcodeT opcode;
        instrBodyT body;
    } instrT;

endpackage

`default_nettype wire
